//--- hdl/iso_axi_pkg.sv
// AXI write channel definitions for the upstream isolator
// holds the channel widths and the packed AW, W and B payloads
// shared by the isolator blocks and the testbench

package iso_axi_pkg;

  // width of the AXI write id
  localparam int id_w = 4;

  // address and data widths of the write path
  localparam int addr_w = 32;
  localparam int data_w = 32;

  // one strobe bit for every byte lane of the data bus
  localparam int strb_w = data_w / 8;

  // outstanding-write counter width, so up to 63 writes may wait for B
  localparam int cnt_w = 6;

  // write address payload
  // bursts are not supported, so only id and address travel on AW
  typedef struct packed {
    logic [id_w-1:0]   id;
    logic [addr_w-1:0] addr;
  } aw_t;

  // write data payload
  // every write is a single beat and WLAST is implied
  typedef struct packed {
    logic [data_w-1:0] data;
    logic [strb_w-1:0] strb;
  } w_t;

  // write response payload
  // resp keeps the AXI encoding, OKAY is 2'b00
  typedef struct packed {
    logic [id_w-1:0] id;
    logic [1:0]      resp;
  } b_t;

endpackage

//--- hdl/iso_ctrl_pkg.sv
// Control definitions for the upstream isolator
// state encoding of the sequencer, the configuration register map
// and the layout of the status word

package iso_ctrl_pkg;

  // width of a configuration bus word
  localparam int cfg_w = 32;

  // sequencer states, in the order the isolation walks through them
  typedef enum logic [1:0] {
    normal      = 2'b00,
    align_write = 2'b01,
    isolate     = 2'b10,
    flush       = 2'b11
  } iso_state_e;

  // configuration register addresses
  // the fourth code is unmapped and reads back as zero
  typedef enum logic [1:0] {
    reg_ctrl   = 2'b00,
    reg_status = 2'b01,
    reg_count  = 2'b10
  } reg_addr_e;

  // status word returned from reg_status, zero extended to cfg_w
  // isolate_done sits in the top bit of the packed field
  typedef struct packed {
    logic                           isolate_done;
    iso_state_e                     state;
    logic [iso_axi_pkg::cnt_w-1:0]  out_cnt;
  } status_t;

endpackage

//--- hdl/iso_ctrl_regs.sv
// Configuration registers of the upstream isolator
// reg_ctrl holds the isolate request bit, reg_status reports the
// sequencer state and outstanding writes, reg_count counts isolations

`timescale 1ns/1ps

module iso_ctrl_regs (
  input  logic                             clk,
  input  logic                             rst_n,
  input  logic                             cfg_wr,
  input  logic                             cfg_rd,
  input  iso_ctrl_pkg::reg_addr_e          cfg_addr,
  input  logic [iso_ctrl_pkg::cfg_w-1:0]   cfg_wdata,
  output logic [iso_ctrl_pkg::cfg_w-1:0]   cfg_rdata,
  output logic                             iso_req,
  input  logic                             iso_done,
  input  iso_ctrl_pkg::iso_state_e         state,
  input  logic [iso_axi_pkg::cnt_w-1:0]    out_cnt
);

  iso_ctrl_pkg::status_t                status;
  logic [iso_ctrl_pkg::cfg_w-1:0]       status_word;
  logic [iso_ctrl_pkg::cfg_w-1:0]       iso_cnt;
  logic                                 iso_done_q;

  // live status snapshot, the upper bits of the word read as zero
  assign status.isolate_done = iso_done;
  assign status.state        = state;
  assign status.out_cnt      = out_cnt;
  assign status_word = {{(iso_ctrl_pkg::cfg_w - $bits(iso_ctrl_pkg::status_t)){1'b0}}, status};

  // the request bit follows bit 0 of a write to reg_ctrl
  // iso_done is edge detected so each finished isolation counts once
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      iso_req    <= 1'b0;
      iso_cnt    <= '0;
      iso_done_q <= 1'b0;
    end else begin
      iso_done_q <= iso_done;
      if (cfg_wr && (cfg_addr == iso_ctrl_pkg::reg_ctrl)) begin
        iso_req <= cfg_wdata[0];
      end
      if (iso_done && !iso_done_q) begin
        iso_cnt <= iso_cnt + 1'b1;
      end
    end
  end

  // read data is registered and valid the cycle after the strobe
  always_ff @(posedge clk) begin
    if (cfg_rd) begin
      case (cfg_addr)
        iso_ctrl_pkg::reg_ctrl:   cfg_rdata <= {{(iso_ctrl_pkg::cfg_w-1){1'b0}}, iso_req};
        iso_ctrl_pkg::reg_status: cfg_rdata <= status_word;
        iso_ctrl_pkg::reg_count:  cfg_rdata <= iso_cnt;
        default:                  cfg_rdata <= '0;
      endcase
    end
  end

  // the configuration master issues one access per cycle
  a_no_wr_rd_same_cycle: assert property (@(posedge clk) disable iff (!rst_n)
    !(cfg_wr && cfg_rd));

endmodule

//--- hdl/iso_us_fsm.sv
// Upstream isolator sequencer
// blocks new writes and aligns AW with W, then waits for the
// downstream side to drain and holds until the request is dropped

`timescale 1ns/1ps

module iso_us_fsm (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      iso_req,
  output logic                      iso_done,
  output logic                      hold_req,
  input  logic                      align_done,
  output logic                      trk_req,
  input  logic                      trk_done,
  output iso_ctrl_pkg::iso_state_e  state
);

  iso_ctrl_pkg::iso_state_e state_next;

  // state register, every transition lands one cycle after its condition
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= iso_ctrl_pkg::normal;
    end else begin
      state <= state_next;
    end
  end

  // next state and the level outputs decoded from the current state
  always_comb begin
    state_next = state;
    hold_req   = 1'b0;
    trk_req    = 1'b0;
    iso_done   = 1'b0;
    unique case (state)
      iso_ctrl_pkg::normal: begin
        // traffic passes freely until software asks for isolation
        if (iso_req) begin
          state_next = iso_ctrl_pkg::align_write;
        end
      end
      iso_ctrl_pkg::align_write: begin
        // new writes are held while the lagging channel catches up
        hold_req = 1'b1;
        if (align_done) begin
          state_next = iso_ctrl_pkg::isolate;
        end
      end
      iso_ctrl_pkg::isolate: begin
        // isolation is reported from here on, the tracker checks for drain
        hold_req = 1'b1;
        trk_req  = 1'b1;
        iso_done = 1'b1;
        if (!iso_req && trk_done) begin
          state_next = iso_ctrl_pkg::flush;
        end
      end
      iso_ctrl_pkg::flush: begin
        // stay held until the tracker has answered the dropped request
        hold_req = 1'b1;
        iso_done = 1'b1;
        if (!trk_done) begin
          state_next = iso_ctrl_pkg::normal;
        end
      end
      default: begin
        state_next = iso_ctrl_pkg::normal;
      end
    endcase
  end

  // the state register never carries an unknown code
  a_state_legal: assert property (@(posedge clk) disable iff (!rst_n)
    !$isunknown(state));

endmodule

//--- hdl/iso_write_align.sv
// AW and W alignment gate of the upstream isolator
// passes both channels straight through in normal operation and under
// hold lets only the lagging channel move until every address has its data

`timescale 1ns/1ps

module iso_write_align (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               hold_req,
  output logic               align_done,
  input  iso_axi_pkg::aw_t   us_aw,
  input  logic               us_aw_valid,
  output logic               us_aw_ready,
  input  iso_axi_pkg::w_t    us_w,
  input  logic               us_w_valid,
  output logic               us_w_ready,
  output iso_axi_pkg::aw_t   ds_aw,
  output logic               ds_aw_valid,
  input  logic               ds_aw_ready,
  output iso_axi_pkg::w_t    ds_w,
  output logic               ds_w_valid,
  input  logic               ds_w_ready
);

  // accepted AW beats minus accepted W beats, positive means W is behind
  logic signed [iso_axi_pkg::cnt_w:0] balance;
  logic                               bal_zero;
  logic                               bal_neg;
  logic                               bal_max;
  logic                               bal_min;
  logic                               aw_open;
  logic                               w_open;
  logic                               aw_fire;
  logic                               w_fire;

  assign bal_zero = (balance == '0);
  assign bal_neg  = balance[iso_axi_pkg::cnt_w];
  assign bal_max  = !bal_neg && (&balance[iso_axi_pkg::cnt_w-1:0]);
  assign bal_min  = bal_neg && !(|balance[iso_axi_pkg::cnt_w-1:0]);

  // under hold only the channel that is behind may move
  // an AW opens when data ran ahead, a W opens when an address waits
  assign aw_open = !hold_req || bal_neg;
  assign w_open  = !hold_req || (!bal_neg && !bal_zero);

  // payloads always pass, only the handshake is gated
  assign ds_aw       = us_aw;
  assign ds_w        = us_w;
  assign ds_aw_valid = us_aw_valid && aw_open;
  assign us_aw_ready = ds_aw_ready && aw_open;
  assign ds_w_valid  = us_w_valid && w_open;
  assign us_w_ready  = ds_w_ready && w_open;

  assign aw_fire = ds_aw_valid && ds_aw_ready;
  assign w_fire  = ds_w_valid && ds_w_ready;

  // alignment is complete once hold is up and nothing is unbalanced
  assign align_done = hold_req && bal_zero;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      balance <= '0;
    end else begin
      // an AW and a W in the same cycle leave the balance unchanged
      case ({aw_fire, w_fire})
        2'b10:   balance <= balance + 1'b1;
        2'b01:   balance <= balance - 1'b1;
        default: balance <= balance;
      endcase
    end
  end

  // the balance must never wrap past either end of its signed range
  a_balance_range: assert property (@(posedge clk) disable iff (!rst_n)
    !(aw_fire && !w_fire && bal_max) && !(w_fire && !aw_fire && bal_min));

endmodule

//--- hdl/iso_resp_tracker.sv
// Outstanding write tracker of the upstream isolator
// counts writes sent downstream that still wait for B and answers
// a drain request once the count has reached zero

`timescale 1ns/1ps

module iso_resp_tracker (
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic                           aw_fire,
  input  logic                           b_fire,
  input  logic                           trk_req,
  output logic                           trk_done,
  output logic [iso_axi_pkg::cnt_w-1:0]  out_cnt
);

  logic [iso_axi_pkg::cnt_w-1:0] cnt_next;
  logic                          cnt_zero;

  assign cnt_zero = (out_cnt == '0);

  // an address and a response in the same cycle cancel out
  always_comb begin
    case ({aw_fire, b_fire})
      2'b10:   cnt_next = out_cnt + 1'b1;
      2'b01:   cnt_next = out_cnt - 1'b1;
      default: cnt_next = out_cnt;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      out_cnt  <= '0;
      trk_done <= 1'b0;
    end else begin
      out_cnt <= cnt_next;
      // done follows the request, gated by an empty count on the way up
      // new addresses are blocked under hold so the count stays at zero
      if (!trk_req) begin
        trk_done <= 1'b0;
      end else if (cnt_zero) begin
        trk_done <= 1'b1;
      end
    end
  end

  // a response always belongs to a write counted earlier
  a_no_b_at_zero: assert property (@(posedge clk) disable iff (!rst_n)
    b_fire |-> !cnt_zero);

  // the counter has no saturation logic, so it must never be driven past full
  a_cnt_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
    (aw_fire && !b_fire) |-> !(&out_cnt));

endmodule

//--- hdl/iso_us_top.sv
// Upstream AXI write isolator
// joins the configuration registers, the sequencer, the AW/W aligner
// and the outstanding write tracker, B is routed straight through

`timescale 1ns/1ps

module iso_us_top (
  input  logic                             clk,
  input  logic                             rst_n,
  // configuration port
  input  logic                             cfg_wr,
  input  logic                             cfg_rd,
  input  iso_ctrl_pkg::reg_addr_e          cfg_addr,
  input  logic [iso_ctrl_pkg::cfg_w-1:0]   cfg_wdata,
  output logic [iso_ctrl_pkg::cfg_w-1:0]   cfg_rdata,
  // upstream manager side
  input  iso_axi_pkg::aw_t                 us_aw,
  input  logic                             us_aw_valid,
  output logic                             us_aw_ready,
  input  iso_axi_pkg::w_t                  us_w,
  input  logic                             us_w_valid,
  output logic                             us_w_ready,
  output iso_axi_pkg::b_t                  us_b,
  output logic                             us_b_valid,
  input  logic                             us_b_ready,
  // downstream subordinate side
  output iso_axi_pkg::aw_t                 ds_aw,
  output logic                             ds_aw_valid,
  input  logic                             ds_aw_ready,
  output iso_axi_pkg::w_t                  ds_w,
  output logic                             ds_w_valid,
  input  logic                             ds_w_ready,
  input  iso_axi_pkg::b_t                  ds_b,
  input  logic                             ds_b_valid,
  output logic                             ds_b_ready
);

  logic                           iso_req;
  logic                           iso_done;
  logic                           hold_req;
  logic                           align_done;
  logic                           trk_req;
  logic                           trk_done;
  logic                           aw_fire;
  logic                           b_fire;
  logic [iso_axi_pkg::cnt_w-1:0]  out_cnt;
  iso_ctrl_pkg::iso_state_e       state;

  // B is never gated so outstanding writes can always drain
  assign us_b       = ds_b;
  assign us_b_valid = ds_b_valid;
  assign ds_b_ready = us_b_ready;

  // the tracker counts handshakes seen on the downstream side
  assign aw_fire = ds_aw_valid && ds_aw_ready;
  assign b_fire  = ds_b_valid && ds_b_ready;

  iso_ctrl_regs u_regs (
    .clk, .rst_n, .cfg_wr, .cfg_rd, .cfg_addr, .cfg_wdata, .cfg_rdata,
    .iso_req, .iso_done, .state, .out_cnt
  );

  iso_us_fsm u_fsm (
    .clk, .rst_n, .iso_req, .iso_done, .hold_req, .align_done,
    .trk_req, .trk_done, .state
  );

  iso_write_align u_align (
    .clk, .rst_n, .hold_req, .align_done,
    .us_aw, .us_aw_valid, .us_aw_ready, .us_w, .us_w_valid, .us_w_ready,
    .ds_aw, .ds_aw_valid, .ds_aw_ready, .ds_w, .ds_w_valid, .ds_w_ready
  );

  iso_resp_tracker u_trk (
    .clk, .rst_n, .aw_fire, .b_fire, .trk_req, .trk_done, .out_cnt
  );

endmodule

//--- dv/tb_clk_gen.sv
// Clock and reset source for the isolator testbench
// makes a 4 ns clock and holds the synchronous reset low for 8 cycles

`timescale 1ns/1ps

module tb_clk_gen (
  output logic clk,
  output logic rst_n
);

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // reset is let go on a rising edge, like every other driven input
  initial begin
    rst_n = 1'b0;
    repeat (8) @(posedge clk);
    rst_n <= 1'b1;
  end

endmodule

//--- dv/tb_iso_us.sv
// Testbench for the upstream AXI write isolator
// replays the steps of dv/iso_us_tests.txt against the DUT and models the
// downstream subordinate, which takes AW and W at once and holds B back

`timescale 1ns/1ps

module tb_iso_us;

  logic                            clk;
  logic                            rst_n;
  logic                            cfg_wr;
  logic                            cfg_rd;
  iso_ctrl_pkg::reg_addr_e         cfg_addr;
  logic [iso_ctrl_pkg::cfg_w-1:0]  cfg_wdata;
  logic [iso_ctrl_pkg::cfg_w-1:0]  cfg_rdata;
  iso_axi_pkg::aw_t                us_aw;
  logic                            us_aw_valid;
  logic                            us_aw_ready;
  iso_axi_pkg::w_t                 us_w;
  logic                            us_w_valid;
  logic                            us_w_ready;
  iso_axi_pkg::b_t                 us_b;
  logic                            us_b_valid;
  logic                            us_b_ready;
  iso_axi_pkg::aw_t                ds_aw;
  logic                            ds_aw_valid;
  logic                            ds_aw_ready;
  iso_axi_pkg::w_t                 ds_w;
  logic                            ds_w_valid;
  logic                            ds_w_ready;
  iso_axi_pkg::b_t                 ds_b;
  logic                            ds_b_valid;
  logic                            ds_b_ready;

  // step bookkeeping, step_ok is cleared by any check that fails
  int   n_tests;
  int   n_fail;
  logic step_ok;
  logic timed_out;

  tb_clk_gen clk_gen (.clk, .rst_n);

  iso_us_top uut (.*);

  task automatic check_aw(input string name, input iso_axi_pkg::aw_t exp,
                          input iso_axi_pkg::aw_t act);
    if (act !== exp) begin
      $display("[FAIL] %s expected id=%h addr=%h actual id=%h addr=%h",
               name, exp.id, exp.addr, act.id, act.addr);
      step_ok = 1'b0;
    end
  endtask

  task automatic check_w(input string name, input iso_axi_pkg::w_t exp,
                         input iso_axi_pkg::w_t act);
    if (act !== exp) begin
      $display("[FAIL] %s expected data=%h strb=%h actual data=%h strb=%h",
               name, exp.data, exp.strb, act.data, act.strb);
      step_ok = 1'b0;
    end
  endtask

  task automatic check_b(input string name, input iso_axi_pkg::b_t exp,
                         input iso_axi_pkg::b_t act);
    if (act !== exp) begin
      $display("[FAIL] %s expected id=%h resp=%h actual id=%h resp=%h",
               name, exp.id, exp.resp, act.id, act.resp);
      step_ok = 1'b0;
    end
  endtask

  task automatic check_status(input string name, input iso_ctrl_pkg::status_t exp,
                              input iso_ctrl_pkg::status_t act);
    if (act !== exp) begin
      $display("[FAIL] %s expected done=%0d state=%0d cnt=%0d actual done=%0d state=%0d cnt=%0d",
               name, exp.isolate_done, exp.state, exp.out_cnt,
               act.isolate_done, act.state, act.out_cnt);
      step_ok = 1'b0;
    end
  endtask

  task automatic check_word(input string name, input logic [iso_ctrl_pkg::cfg_w-1:0] exp,
                            input logic [iso_ctrl_pkg::cfg_w-1:0] act);
    if (act !== exp) begin
      $display("[FAIL] %s expected %h actual %h", name, exp, act);
      step_ok = 1'b0;
    end
  endtask

  task automatic report_timeout(input string name, input string what);
    $display("%s: gave up after 200 cycles waiting for the %s", name, what);
    step_ok   = 1'b0;
    timed_out = 1'b1;
  endtask

  task automatic write_reg(input iso_ctrl_pkg::reg_addr_e addr,
                           input logic [iso_ctrl_pkg::cfg_w-1:0] data);
    @(posedge clk);
    cfg_wr    <= 1'b1;
    cfg_addr  <= addr;
    cfg_wdata <= data;
    @(posedge clk);
    cfg_wr <= 1'b0;
  endtask

  // read data is registered, so it is taken one edge after the strobe edge
  task automatic read_reg(input iso_ctrl_pkg::reg_addr_e addr,
                          output logic [iso_ctrl_pkg::cfg_w-1:0] data);
    @(posedge clk);
    cfg_rd   <= 1'b1;
    cfg_addr <= addr;
    @(posedge clk);
    cfg_rd <= 1'b0;
    @(posedge clk);
    data = cfg_rdata;
  endtask

  // polls reg_status until it matches or the cycle budget runs out
  task automatic wait_status(input string name, input iso_ctrl_pkg::status_t exp);
    logic [iso_ctrl_pkg::cfg_w-1:0] word;
    iso_ctrl_pkg::status_t          act;
    int                             cycles;
    cycles = 0;
    do begin
      read_reg(iso_ctrl_pkg::reg_status, word);
      act = word[$bits(act)-1:0];
      cycles += 3;
    end while (act !== exp && cycles < 200);
    check_status(name, exp, act);
  endtask

  // the address seen downstream on the handshake edge must equal the upstream one
  task automatic send_aw(input string name, input iso_axi_pkg::aw_t aw);
    int cycles;
    cycles = 0;
    @(posedge clk);
    us_aw       <= aw;
    us_aw_valid <= 1'b1;
    do begin
      @(posedge clk);
      cycles++;
    end while (!us_aw_ready && cycles < 200);
    us_aw_valid <= 1'b0;
    if (us_aw_ready) begin
      if (!ds_aw_valid) begin
        $display("%s: the AW was accepted upstream but not offered downstream", name);
        step_ok = 1'b0;
      end
      check_aw(name, aw, ds_aw);
    end else begin
      report_timeout(name, "upstream AW handshake");
    end
  endtask

  task automatic send_w(input string name, input iso_axi_pkg::w_t w);
    int cycles;
    cycles = 0;
    @(posedge clk);
    us_w       <= w;
    us_w_valid <= 1'b1;
    do begin
      @(posedge clk);
      cycles++;
    end while (!us_w_ready && cycles < 200);
    us_w_valid <= 1'b0;
    if (us_w_ready) begin
      if (!ds_w_valid) begin
        $display("%s: the W was accepted upstream but not offered downstream", name);
        step_ok = 1'b0;
      end
      check_w(name, w, ds_w);
    end else begin
      report_timeout(name, "upstream W handshake");
    end
  endtask

  // an AW offered while isolated must see neither ready nor a downstream valid
  task automatic stall_aw(input string name, input iso_axi_pkg::aw_t aw);
    int   cycles;
    logic taken;
    taken = 1'b0;
    @(posedge clk);
    us_aw       <= aw;
    us_aw_valid <= 1'b1;
    for (cycles = 0; cycles < 8; cycles++) begin
      @(posedge clk);
      if (us_aw_ready || ds_aw_valid) begin
        taken = 1'b1;
      end
    end
    us_aw_valid <= 1'b0;
    if (taken) begin
      $display("%s: an AW got through while the port was isolated", name);
      step_ok = 1'b0;
    end
  endtask

  // the downstream model returns B only here, the manager side always takes it
  task automatic release_b(input string name, input iso_axi_pkg::b_t b);
    int cycles;
    cycles = 0;
    @(posedge clk);
    ds_b       <= b;
    ds_b_valid <= 1'b1;
    do begin
      @(posedge clk);
      cycles++;
    end while (!(ds_b_ready && us_b_valid) && cycles < 200);
    ds_b_valid <= 1'b0;
    if (ds_b_ready && us_b_valid) begin
      check_b(name, b, us_b);
    end else begin
      report_timeout(name, "B handshake");
    end
  endtask

  initial begin
    int                             fd;
    int                             fields;
    int                             cycles;
    logic                           reading;
    string                          line;
    string                          cmd;
    string                          name;
    logic [31:0]                    a0;
    logic [31:0]                    a1;
    logic [31:0]                    a2;
    logic [iso_ctrl_pkg::cfg_w-1:0] word;
    iso_axi_pkg::aw_t               aw_v;
    iso_axi_pkg::w_t                w_v;
    iso_axi_pkg::b_t                b_v;
    iso_ctrl_pkg::status_t          st_v;

    cfg_wr      = 1'b0;
    cfg_rd      = 1'b0;
    cfg_addr    = iso_ctrl_pkg::reg_ctrl;
    cfg_wdata   = '0;
    us_aw       = '0;
    us_aw_valid = 1'b0;
    us_w        = '0;
    us_w_valid  = 1'b0;
    us_b_ready  = 1'b0;
    ds_aw_ready = 1'b0;
    ds_w_ready  = 1'b0;
    ds_b        = '0;
    ds_b_valid  = 1'b0;
    n_tests     = 0;
    n_fail      = 0;
    timed_out   = 1'b0;

    cycles = 0;
    while (rst_n !== 1'b1 && cycles < 200) begin
      @(posedge clk);
      cycles++;
    end
    if (rst_n !== 1'b1) begin
      $display("reset was never released");
      timed_out = 1'b1;
      n_fail++;
    end

    // the subordinate and the manager side are always ready after reset
    @(posedge clk);
    ds_aw_ready <= 1'b1;
    ds_w_ready  <= 1'b1;
    us_b_ready  <= 1'b1;

    fd = $fopen("dv/iso_us_tests.txt", "r");
    if (fd == 0) begin
      $display("could not open dv/iso_us_tests.txt");
      n_fail++;
    end else begin
      reading = !timed_out;
      while (reading) begin
        if ($fgets(line, fd) == 0) begin
          reading = 1'b0;
        end else begin
          fields = 0;
          if (line.len() > 1 && line[0] != "#") begin
            fields = $sscanf(line, "%s %s %h %h %h", cmd, name, a0, a1, a2);
          end
          if (fields == 5) begin
            step_ok = 1'b1;
            case (cmd)
              "wr": begin
                write_reg(iso_ctrl_pkg::reg_addr_e'(a0[1:0]), a1);
              end
              "stat": begin
                st_v.isolate_done = a0[0];
                st_v.state        = iso_ctrl_pkg::iso_state_e'(a1[1:0]);
                st_v.out_cnt      = a2[iso_axi_pkg::cnt_w-1:0];
                wait_status(name, st_v);
              end
              "cnt": begin
                read_reg(iso_ctrl_pkg::reg_count, word);
                check_word(name, a0, word);
              end
              "aw", "awblk": begin
                aw_v.id   = a0[iso_axi_pkg::id_w-1:0];
                aw_v.addr = a1;
                if (cmd == "aw") begin
                  send_aw(name, aw_v);
                end else begin
                  stall_aw(name, aw_v);
                end
              end
              "w": begin
                w_v.data = a0;
                w_v.strb = a1[iso_axi_pkg::strb_w-1:0];
                send_w(name, w_v);
              end
              "b": begin
                b_v.id   = a0[iso_axi_pkg::id_w-1:0];
                b_v.resp = a1[1:0];
                release_b(name, b_v);
              end
              default: begin
                $display("%s: the step kind %s is not known", name, cmd);
                step_ok = 1'b0;
              end
            endcase
            n_tests++;
            if (step_ok) begin
              $display("[PASS] %s", name);
            end else begin
              n_fail++;
            end
            // a stuck handshake leaves the DUT in an unknown place, so stop here
            if (timed_out) begin
              reading = 1'b0;
            end
          end
        end
      end
      $fclose(fd);
    end

    $display("%0d tests run, %0d failed", n_tests, n_fail);
    if (n_fail == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

//--- dv/iso_us_tests.txt
# columns: step test_name arg0 arg1 arg2, all args hex and unused ones 0
# wr addr data | stat done state cnt | cnt value | aw id addr | awblk id addr | w data strb | b id resp
aw    pass_aw       3         10000040  0
w     pass_w        cafe0001  f         0
stat  pass_cnt1     0         0         1
b     pass_b        3         0         0
stat  pass_cnt0     0         0         0
wr    iso_set       0         1         0
stat  iso_idle      1         2         0
awblk iso_aw_blk    5         20000000  0
cnt   iso_count1    1         0         0
wr    iso_clr       0         0         0
stat  iso_back      0         0         0
aw    align_aw      6         30000010  0
wr    align_set     0         1         0
stat  align_wait    0         1         1
w     align_w       12345678  3         0
stat  align_done    1         2         1
b     align_b       6         2         0
stat  align_drain   1         2         0
wr    align_clr     0         0         0
stat  align_back    0         0         0
aw    out_aw        9         40000000  0
w     out_w         0badf00d  f         0
wr    out_set       0         1         0
stat  out_held      1         2         1
b     out_b         9         0         0
stat  out_drain     1         2         0
wr    out_clr       0         0         0
stat  out_back      0         0         0
cnt   final_count   3         0         0
aw    final_aw      a         50000004  0
w     final_w       5a5aa5a5  c         0
b     final_b       a         1         0
stat  final_idle    0         0         0

//--- list.f
hdl/iso_axi_pkg.sv
hdl/iso_ctrl_pkg.sv
hdl/iso_ctrl_regs.sv
hdl/iso_us_fsm.sv
hdl/iso_write_align.sv
hdl/iso_resp_tracker.sv
hdl/iso_us_top.sv
dv/tb_clk_gen.sv
dv/tb_iso_us.sv

//--- run.sh
#!/bin/sh
# build the isolator testbench with Verilator, run it and check the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tb_iso_us \
  -Mdir obj_dir -o tb_iso_us -f list.f

./obj_dir/tb_iso_us > sim.log 2>&1
cat sim.log

if grep -q "Test failed" sim.log; then
  exit 1
fi
grep -q "Test passed" sim.log
